// ==== execPkg.sv ====
`default_nettype none

package execPkg;

    localparam int DataWidth = 32;
    localparam int RegIdWidth = 5;
    localparam int MulSteps = 4; // one 8-bit slice of b per step.

    // one instruction word, read either as R-type or as I-type.
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

    localparam logic [5:0] OpSpecial  = 6'h00;
    localparam logic [5:0] OpSpecial2 = 6'h1c;
    localparam logic [5:0] OpAddi     = 6'h08;
    localparam logic [5:0] OpAddiu    = 6'h09;
    localparam logic [5:0] OpLui      = 6'h0f;
    localparam logic [5:0] OpLb       = 6'h20;
    localparam logic [5:0] OpLh       = 6'h21;
    localparam logic [5:0] OpLw       = 6'h23;
    localparam logic [5:0] OpLbu      = 6'h24;
    localparam logic [5:0] OpLhu      = 6'h25;
    localparam logic [5:0] OpSb       = 6'h28;
    localparam logic [5:0] OpSh       = 6'h29;
    localparam logic [5:0] OpSw       = 6'h2b;

    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnMul  = 6'h02; // under OpSpecial2.
    localparam logic [5:0] FnAdd  = 6'h20;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnSlt  = 6'h2a;

    localparam logic [3:0] AluAdd  = 4'd0;
    localparam logic [3:0] AluAddS = 4'd1; // add that flags signed overflow.
    localparam logic [3:0] AluSub  = 4'd2;
    localparam logic [3:0] AluAnd  = 4'd3;
    localparam logic [3:0] AluOr   = 4'd4;
    localparam logic [3:0] AluSlt  = 4'd5;
    localparam logic [3:0] AluSll  = 4'd6;
    localparam logic [3:0] AluLui  = 4'd7;

    localparam logic [2:0] LdNone  = 3'd0;
    localparam logic [2:0] LdWord  = 3'd1;
    localparam logic [2:0] LdHalf  = 3'd2;
    localparam logic [2:0] LdHalfU = 3'd3;
    localparam logic [2:0] LdByte  = 3'd4;
    localparam logic [2:0] LdByteU = 3'd5;

    localparam logic [1:0] StNone = 2'd0;
    localparam logic [1:0] StWord = 2'd1;
    localparam logic [1:0] StHalf = 2'd2;
    localparam logic [1:0] StByte = 2'd3;

endpackage

`default_nettype wire

// ==== operandForward.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandForward import execPkg::*; (
    input  wire [RegIdWidth-1:0] rsNum,
    input  wire [RegIdWidth-1:0] rtNum,
    input  wire [DataWidth-1:0]  rsData,
    input  wire [DataWidth-1:0]  rtData,
    input  wire                  eRegWrite,
    input  wire                  eMemRead,
    input  wire [RegIdWidth-1:0] eRegId,
    input  wire [DataWidth-1:0]  eData,
    input  wire                  mRegWrite,
    input  wire [RegIdWidth-1:0] mRegId,
    input  wire [DataWidth-1:0]  mData,
    output logic [DataWidth-1:0] rsVal,
    output logic [DataWidth-1:0] rtVal
);

    function automatic logic [DataWidth-1:0] pick(
        input logic [RegIdWidth-1:0] num,
        input logic [DataWidth-1:0]  rfData,
        input logic                  eHit,
        input logic                  mHit
    );
        if (num == '0) return '0; // $zero.
        if (eHit) return eData;
        if (mHit) return mData;
        return rfData;
    endfunction

    // a load in the execute register has no data yet.
    always_comb begin
        rsVal = pick(rsNum, rsData, eRegWrite && !eMemRead && eRegId == rsNum,
                     mRegWrite && mRegId == rsNum);
        rtVal = pick(rtNum, rtData, eRegWrite && !eMemRead && eRegId == rtNum,
                     mRegWrite && mRegId == rtNum);
    end

endmodule

`default_nettype wire

// ==== aluCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCore import execPkg::*; (
    input  wire [3:0]            aluOp,
    input  wire [DataWidth-1:0]  rsVal,
    input  wire [DataWidth-1:0]  rtVal,
    input  wire [15:0]           imm,
    input  wire                  useImm,
    input  wire                  immSigned,
    input  wire [4:0]            shamt,
    output logic [DataWidth-1:0] aluResult,
    output logic                 overflow
);

    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] sum;

    assign immExt = immSigned ? {{(DataWidth-16){imm[15]}}, imm} : {{(DataWidth-16){1'b0}}, imm};
    assign opB = useImm ? immExt : rtVal;
    assign sum = rsVal + opB;

    always_comb begin
        overflow = 1'b0;
        case (aluOp)
            AluAdd: aluResult = sum; // also load/store address.
            AluAddS: begin
                aluResult = sum;
                // same operand signs, different result sign.
                overflow = (rsVal[DataWidth-1] == opB[DataWidth-1]) &&
                           (sum[DataWidth-1] != rsVal[DataWidth-1]);
            end
            AluSub: aluResult = rsVal - opB;
            AluAnd: aluResult = rsVal & opB;
            AluOr: aluResult = rsVal | opB;
            AluSlt: begin
                aluResult = '0;
                aluResult[0] = $signed(rsVal) < $signed(opB);
            end
            AluSll: aluResult = rtVal << shamt;
            AluLui: aluResult = {imm, {(DataWidth-16){1'b0}}};
            default: aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== iterMultiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module iterMultiplier import execPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire                  start,
    input  wire                  abort,
    input  wire                  hold,
    input  wire [DataWidth-1:0]  a,
    input  wire [DataWidth-1:0]  b,
    output logic                 busy,
    output logic                 done,
    output logic [DataWidth-1:0] product
);

    logic [DataWidth-1:0]         aReg;
    logic [DataWidth-1:0]         bReg;
    logic [DataWidth-1:0]         acc;
    logic [$clog2(MulSteps)-1:0]  stepCnt;
    logic [7:0]                   bSlice;
    logic [DataWidth-1:0]         partial;
    logic                         lastStep;

    assign bSlice = bReg[{stepCnt, 3'b000} +: 8];
    // a times one slice, moved up to that slice's weight.
    assign partial = (aReg * {{(DataWidth-8){1'b0}}, bSlice}) << {stepCnt, 3'b000};
    assign lastStep = stepCnt == ($clog2(MulSteps))'(MulSteps - 1);
    assign product = acc;

    always_ff @(posedge Clk) begin
        if (reset || abort) begin
            busy <= 1'b0;
            done <= 1'b0;
            stepCnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            stepCnt <= '0;
        end else if (!hold) begin
            done <= busy && lastStep; // one-cycle pulse unless held.
            if (busy) begin
                stepCnt <= stepCnt + 1'b1;
                if (lastStep) busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            aReg <= a;
            bReg <= b;
            acc <= '0;
        end else if (busy && !hold) begin
            acc <= acc + partial; // low 32 bits only.
        end
    end

endmodule

`default_nettype wire

// ==== memAccessDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module memAccessDecode import execPkg::*; (
    input  wire [2:0]            loadKind,
    input  wire [1:0]            storeSize,
    input  wire [DataWidth-1:0]  address,
    input  wire [DataWidth-1:0]  rtVal,
    output logic [3:0]           byteEnable,
    output logic                 unaligned,
    output logic [DataWidth-1:0] storeData,
    output logic                 memRead
);

    logic [1:0] offset;

    assign offset = address[1:0];

    always_comb begin
        unaligned = 1'b0;
        byteEnable = 4'b0000; // loads enable no lanes.
        storeData = rtVal;
        case (loadKind)
            LdWord: unaligned = offset != 2'b00;
            LdHalf, LdHalfU: unaligned = offset[0];
            default: ;
        endcase
        case (storeSize)
            StWord: begin
                unaligned = offset != 2'b00;
                byteEnable = 4'b1111;
            end
            StHalf: begin
                unaligned = offset[0];
                byteEnable = 4'b0011 << offset;
                storeData = {2{rtVal[15:0]}};
            end
            StByte: begin
                byteEnable = 4'b0001 << offset;
                storeData = {4{rtVal[7:0]}};
            end
            default: ;
        endcase
        if (unaligned) byteEnable = 4'b0000;
    end

    assign memRead = (loadKind != LdNone) && !unaligned;

endmodule

`default_nettype wire

// ==== execControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module execControl import execPkg::*; (
    input  wire                   Clk,
    input  wire                   reset,
    input  wire                   flush,
    input  wire                   memStall,
    input  wire                   inValid,
    input  wire instrWord         instr,
    input  wire [DataWidth-1:0]   pc,
    input  wire [DataWidth-1:0]   aluResult,
    input  wire                   overflow,
    input  wire [3:0]             byteEnable,
    input  wire                   unaligned,
    input  wire [DataWidth-1:0]   storeData,
    input  wire                   memRead,
    input  wire                   mulDone,
    input  wire [DataWidth-1:0]   product,
    output logic [3:0]            aluOp,
    output logic                  useImm,
    output logic                  immSigned,
    output logic [4:0]            shamt,
    output logic [15:0]           imm,
    output logic [2:0]            loadKind,
    output logic [1:0]            storeSize,
    output logic                  mulStart,
    output logic                  busy,
    output logic                  eValid,
    output logic [DataWidth-1:0]  ePc,
    output logic                  eRegWrite,
    output logic [RegIdWidth-1:0] eRegId,
    output logic [DataWidth-1:0]  eData,
    output logic [DataWidth-1:0]  eWriteMemData,
    output logic [3:0]            eByteEnable,
    output logic                  eMemRead,
    output logic [2:0]            eLoadKind,
    output logic                  eOverflow,
    output logic                  eUnaligned
);

    logic                  regWrite;
    logic [RegIdWidth-1:0] destId;
    logic                  isMul;
    logic                  pendingMul;
    logic [DataWidth-1:0]  mulPc;
    logic [RegIdWidth-1:0] mulRegId;
    logic                  takeNew;
    logic                  takeMul;

    assign shamt = instr.rType.shamt;
    assign imm = instr.iType.imm;

    always_comb begin
        aluOp = AluAdd;
        useImm = 1'b1;
        immSigned = 1'b1;
        regWrite = 1'b0;
        destId = instr.iType.rt;
        loadKind = LdNone;
        storeSize = StNone;
        isMul = 1'b0;
        case (instr.iType.op)
            OpSpecial: begin
                useImm = 1'b0;
                destId = instr.rType.rd;
                regWrite = 1'b1;
                case (instr.rType.funct)
                    FnAddu: aluOp = AluAdd;
                    FnAdd: aluOp = AluAddS;
                    FnSubu: aluOp = AluSub;
                    FnAnd: aluOp = AluAnd;
                    FnOr: aluOp = AluOr;
                    FnSlt: aluOp = AluSlt;
                    FnSll: aluOp = AluSll;
                    default: regWrite = 1'b0; // unknown funct has no effect.
                endcase
            end
            OpSpecial2: isMul = instr.rType.funct == FnMul;
            OpAddiu: regWrite = 1'b1;
            OpAddi: begin
                aluOp = AluAddS;
                regWrite = 1'b1;
            end
            OpLui: begin
                aluOp = AluLui;
                immSigned = 1'b0;
                regWrite = 1'b1;
            end
            OpLw: begin
                loadKind = LdWord;
                regWrite = 1'b1;
            end
            OpLh: begin
                loadKind = LdHalf;
                regWrite = 1'b1;
            end
            OpLhu: begin
                loadKind = LdHalfU;
                regWrite = 1'b1;
            end
            OpLb: begin
                loadKind = LdByte;
                regWrite = 1'b1;
            end
            OpLbu: begin
                loadKind = LdByteU;
                regWrite = 1'b1;
            end
            OpSw: storeSize = StWord;
            OpSh: storeSize = StHalf;
            OpSb: storeSize = StByte;
            default: ;
        endcase
    end

    assign busy = pendingMul;
    assign takeMul = pendingMul && mulDone;
    assign takeNew = inValid && !pendingMul && !isMul;
    assign mulStart = inValid && isMul && !pendingMul && !memStall && !flush;

    // flush wins over stall.
    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            pendingMul <= 1'b0;
            eValid <= 1'b0;
            eRegWrite <= 1'b0;
            eMemRead <= 1'b0;
            eByteEnable <= 4'b0000;
            eOverflow <= 1'b0;
            eUnaligned <= 1'b0;
        end else if (!memStall) begin
            if (takeMul) begin
                pendingMul <= 1'b0;
            end else if (mulStart) begin
                pendingMul <= 1'b1; // bubble goes out meanwhile.
            end
            eValid <= takeMul || takeNew;
            eRegWrite <= takeMul || (takeNew && regWrite && !overflow);
            eMemRead <= takeNew && memRead;
            eByteEnable <= takeNew ? byteEnable : 4'b0000;
            eOverflow <= takeNew && overflow;
            eUnaligned <= takeNew && unaligned;
        end
    end

    always_ff @(posedge Clk) begin
        if (mulStart) begin
            mulPc <= pc;
            mulRegId <= instr.rType.rd;
        end
        if (!memStall) begin
            if (takeMul) begin
                ePc <= mulPc;
                eRegId <= mulRegId;
                eData <= product;
                eWriteMemData <= '0;
                eLoadKind <= LdNone;
            end else if (takeNew) begin
                ePc <= pc;
                eRegId <= destId;
                eData <= aluResult; // address for loads and stores.
                eWriteMemData <= storeData;
                eLoadKind <= loadKind;
            end
        end
    end

endmodule

`default_nettype wire

// ==== execStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module execStage import execPkg::*; (
    input  wire                   Clk,
    input  wire                   reset,
    input  wire                   inValid,
    input  wire instrWord         instr,
    input  wire [DataWidth-1:0]   pc,
    input  wire [DataWidth-1:0]   rsData,
    input  wire [DataWidth-1:0]   rtData,
    input  wire                   mRegWrite,
    input  wire [RegIdWidth-1:0]  mRegId,
    input  wire [DataWidth-1:0]   mData,
    input  wire                   memStall,
    input  wire                   flush,
    output logic                  busy,
    output logic                  eValid,
    output logic [DataWidth-1:0]  ePc,
    output logic                  eRegWrite,
    output logic [RegIdWidth-1:0] eRegId,
    output logic [DataWidth-1:0]  eData,
    output logic [DataWidth-1:0]  eWriteMemData,
    output logic [3:0]            eByteEnable,
    output logic                  eMemRead,
    output logic [2:0]            eLoadKind,
    output logic                  eOverflow,
    output logic                  eUnaligned
);

    logic [3:0]           aluOp;
    logic                 useImm;
    logic                 immSigned;
    logic [4:0]           shamt;
    logic [15:0]          imm;
    logic [2:0]           loadKind;
    logic [1:0]           storeSize;
    logic                 mulStart;
    logic [DataWidth-1:0] rsVal;
    logic [DataWidth-1:0] rtVal;
    logic [DataWidth-1:0] aluResult;
    logic                 overflow;
    logic [3:0]           byteEnable;
    logic                 unaligned;
    logic [DataWidth-1:0] storeData;
    logic                 memRead;
    logic                 mulDone;
    logic [DataWidth-1:0] product;

    execControl execControl_i (
        .Clk(Clk), .reset(reset), .flush(flush), .memStall(memStall),
        .inValid(inValid), .instr(instr), .pc(pc),
        .aluResult(aluResult), .overflow(overflow),
        .byteEnable(byteEnable), .unaligned(unaligned), .storeData(storeData),
        .memRead(memRead), .mulDone(mulDone), .product(product),
        .aluOp(aluOp), .useImm(useImm), .immSigned(immSigned), .shamt(shamt), .imm(imm),
        .loadKind(loadKind), .storeSize(storeSize), .mulStart(mulStart), .busy(busy),
        .eValid(eValid), .ePc(ePc), .eRegWrite(eRegWrite), .eRegId(eRegId), .eData(eData),
        .eWriteMemData(eWriteMemData), .eByteEnable(eByteEnable), .eMemRead(eMemRead),
        .eLoadKind(eLoadKind), .eOverflow(eOverflow), .eUnaligned(eUnaligned)
    );

    operandForward operandForward_i (
        .rsNum(instr.rType.rs), .rtNum(instr.rType.rt),
        .rsData(rsData), .rtData(rtData),
        .eRegWrite(eRegWrite), .eMemRead(eMemRead), .eRegId(eRegId), .eData(eData),
        .mRegWrite(mRegWrite), .mRegId(mRegId), .mData(mData),
        .rsVal(rsVal), .rtVal(rtVal)
    );

    aluCore aluCore_i (
        .aluOp(aluOp), .rsVal(rsVal), .rtVal(rtVal), .imm(imm),
        .useImm(useImm), .immSigned(immSigned), .shamt(shamt),
        .aluResult(aluResult), .overflow(overflow)
    );

    iterMultiplier iterMultiplier_i (
        .Clk(Clk), .reset(reset), .start(mulStart), .abort(flush), .hold(memStall),
        .a(rsVal), .b(rtVal),
        .busy(), .done(mulDone), .product(product)
    );

    memAccessDecode memAccessDecode_i (
        .loadKind(loadKind), .storeSize(storeSize), .address(aluResult), .rtVal(rtVal),
        .byteEnable(byteEnable), .unaligned(unaligned), .storeData(storeData),
        .memRead(memRead)
    );

endmodule

`default_nettype wire

// ==== tbExecStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbExecStage import execPkg::*; ();

    localparam int NumInstr = 2000;
    localparam int TimeoutCycles = NumInstr * (MulSteps + 3);

    logic                  Clk = 1'b0;
    logic                  reset;
    logic                  inValid;
    instrWord              instr;
    logic [DataWidth-1:0]  pc;
    logic [DataWidth-1:0]  rsData;
    logic [DataWidth-1:0]  rtData;
    logic                  mRegWrite;
    logic [RegIdWidth-1:0] mRegId;
    logic [DataWidth-1:0]  mData;
    logic                  memStall;
    logic                  flush;
    logic                  busy;
    logic                  eValid;
    logic [DataWidth-1:0]  ePc;
    logic                  eRegWrite;
    logic [RegIdWidth-1:0] eRegId;
    logic [DataWidth-1:0]  eData;
    logic [DataWidth-1:0]  eWriteMemData;
    logic [3:0]            eByteEnable;
    logic                  eMemRead;
    logic [2:0]            eLoadKind;
    logic                  eOverflow;
    logic                  eUnaligned;

    // expected state of the execute register.
    logic                  expValid;
    logic [DataWidth-1:0]  expPc;
    logic                  expRegWrite;
    logic [RegIdWidth-1:0] expRegId;
    logic [DataWidth-1:0]  expData;
    logic [DataWidth-1:0]  expWrData;
    logic [3:0]            expBe;
    logic                  expMemRead;
    logic [2:0]            expLoadKind;
    logic                  expOvf;
    logic                  expUna;
    logic                  expStore;
    logic                  pend; // mul in flight.
    int                    pendCnt;
    logic [DataWidth-1:0]  pendPc;
    logic [DataWidth-1:0]  pendProd;
    logic [RegIdWidth-1:0] pendId;
    logic                  accepted;
    int                    issued = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;

    execStage execStage_i (.*);

    always #50 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles++;
        if (cycles > TimeoutCycles + 10) begin
            $display("run timed out after %0d cycles, instruction stream did not drain", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [4:0] pickReg();
        if ($urandom % 4 == 0) return 5'($urandom % 32);
        return 5'($urandom % 4); // bias to a few registers for forwarding.
    endfunction

    function automatic logic [31:0] randOperand();
        case ($urandom % 4)
            0: return 32'($urandom % 16);
            1: return 32'h7fff_fff0 + 32'($urandom % 32); // around signed max.
            default: return $urandom;
        endcase
    endfunction

    function automatic logic addOverflow(input logic [31:0] a, input logic [31:0] b);
        logic [32:0] wide;
        wide = {a[31], a} + {b[31], b};
        return wide[32] != wide[31];
    endfunction

    function automatic instrWord genInstr();
        instrWord w;
        int sel;
        sel = $urandom % 19;
        w = '0;
        w.rType.rs = pickReg();
        w.rType.rt = pickReg();
        if (sel < 8) begin
            w.rType.op = OpSpecial;
            w.rType.rd = pickReg();
            case (sel)
                0: w.rType.funct = FnAddu;
                1: w.rType.funct = FnAdd;
                2: w.rType.funct = FnSubu;
                3: w.rType.funct = FnAnd;
                4: w.rType.funct = FnOr;
                5: w.rType.funct = FnSlt;
                6: begin
                    w.rType.funct = FnSll;
                    w.rType.shamt = 5'($urandom % 32);
                end
                default: begin
                    w.rType.op = OpSpecial2;
                    w.rType.funct = FnMul;
                end
            endcase
        end else begin
            w.iType.imm = 16'($urandom);
            case (sel)
                8: w.iType.op = OpAddiu;
                9: w.iType.op = OpAddi;
                10: w.iType.op = OpLui;
                11: w.iType.op = OpLw;
                12: w.iType.op = OpLh;
                13: w.iType.op = OpLhu;
                14: w.iType.op = OpLb;
                15: w.iType.op = OpLbu;
                16: w.iType.op = OpSw;
                17: w.iType.op = OpSh;
                default: w.iType.op = OpSb;
            endcase
        end
        return w;
    endfunction

    function automatic logic [31:0] fwdValue(input logic [4:0] num, input logic [31:0] rfVal);
        if (num == 5'd0) return 32'd0;
        if (expRegWrite && !expMemRead && expRegId == num) return expData;
        if (mRegWrite && mRegId == num) return mData;
        return rfVal;
    endfunction

    task automatic loadBubble();
        expValid = 1'b0;
        expRegWrite = 1'b0;
        expMemRead = 1'b0;
        expBe = 4'b0000;
        expOvf = 1'b0;
        expUna = 1'b0;
    endtask

    task automatic acceptInstr(input instrWord w, input logic [31:0] pcV,
                               input logic [31:0] rsV, input logic [31:0] rtV);
        logic [31:0] simm;
        logic [31:0] addr;
        logic [3:0]  lanes;
        int          accSize;
        logic        isLoad;
        simm = {{16{w.iType.imm[15]}}, w.iType.imm};
        addr = rsV + simm;
        accSize = 0;
        isLoad = 1'b0;
        if (w.iType.op == OpSpecial2 && w.rType.funct == FnMul) begin
            pend = 1'b1;
            pendCnt = 0;
            pendPc = pcV;
            pendId = w.rType.rd;
            pendProd = rsV * rtV; // low word only.
            loadBubble();
        end else begin
            expValid = 1'b1;
            expPc = pcV;
            expRegWrite = 1'b1;
            expRegId = w.iType.rt;
            expData = '0;
            expWrData = '0;
            expBe = 4'b0000;
            expMemRead = 1'b0;
            expLoadKind = LdNone;
            expOvf = 1'b0;
            expUna = 1'b0;
            expStore = 1'b0;
            case (w.iType.op)
                OpSpecial: begin
                    expRegId = w.rType.rd;
                    case (w.rType.funct)
                        FnAddu: expData = rsV + rtV;
                        FnAdd: begin
                            expData = rsV + rtV;
                            expOvf = addOverflow(rsV, rtV);
                        end
                        FnSubu: expData = rsV - rtV;
                        FnAnd: expData = rsV & rtV;
                        FnOr: expData = rsV | rtV;
                        FnSlt: expData = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
                        default: expData = rtV << w.rType.shamt;
                    endcase
                end
                OpAddiu: expData = rsV + simm;
                OpAddi: begin
                    expData = rsV + simm;
                    expOvf = addOverflow(rsV, simm);
                end
                OpLui: expData = {w.iType.imm, 16'h0000};
                OpLw: begin
                    accSize = 4;
                    isLoad = 1'b1;
                    expLoadKind = LdWord;
                end
                OpLh: begin
                    accSize = 2;
                    isLoad = 1'b1;
                    expLoadKind = LdHalf;
                end
                OpLhu: begin
                    accSize = 2;
                    isLoad = 1'b1;
                    expLoadKind = LdHalfU;
                end
                OpLb: begin
                    accSize = 1;
                    isLoad = 1'b1;
                    expLoadKind = LdByte;
                end
                OpLbu: begin
                    accSize = 1;
                    isLoad = 1'b1;
                    expLoadKind = LdByteU;
                end
                OpSw: accSize = 4;
                OpSh: accSize = 2;
                default: accSize = 1;
            endcase
            if (expOvf) expRegWrite = 1'b0;
            if (accSize != 0) begin
                expData = addr;
                expUna = (addr[1:0] & 2'(accSize - 1)) != 2'b00;
                if (isLoad) begin
                    expMemRead = !expUna;
                end else begin
                    expRegWrite = 1'b0;
                    expStore = 1'b1;
                    lanes = 4'((1 << accSize) - 1) << addr[1:0];
                    expBe = expUna ? 4'b0000 : lanes;
                    expWrData = (accSize == 4) ? rtV :
                                (accSize == 2) ? {2{rtV[15:0]}} : {4{rtV[7:0]}};
                end
            end
        end
    endtask

    // one clock edge of the reference model on the inputs held before it.
    task automatic clockModel();
        logic [31:0] rsV;
        logic [31:0] rtV;
        accepted = 1'b0;
        if (flush) begin
            pend = 1'b0;
            loadBubble();
        end else if (!memStall) begin
            if (pend) begin
                pendCnt++;
                if (pendCnt == MulSteps + 1) begin
                    pend = 1'b0;
                    expValid = 1'b1;
                    expPc = pendPc;
                    expRegWrite = 1'b1;
                    expRegId = pendId;
                    expData = pendProd;
                    expMemRead = 1'b0;
                    expBe = 4'b0000;
                    expLoadKind = LdNone;
                    expOvf = 1'b0;
                    expUna = 1'b0;
                    expStore = 1'b0;
                end else begin
                    loadBubble();
                end
            end else if (inValid) begin
                rsV = fwdValue(instr.rType.rs, rsData);
                rtV = fwdValue(instr.rType.rt, rtData);
                acceptInstr(instr, pc, rsV, rtV);
                accepted = 1'b1;
            end else begin
                loadBubble();
            end
        end
    endtask

    task automatic compareOutputs();
        checkVal("eValid", 32'(eValid), 32'(expValid));
        checkVal("eRegWrite", 32'(eRegWrite), 32'(expRegWrite));
        checkVal("eMemRead", 32'(eMemRead), 32'(expMemRead));
        checkVal("eByteEnable", 32'(eByteEnable), 32'(expBe));
        checkVal("eOverflow", 32'(eOverflow), 32'(expOvf));
        checkVal("eUnaligned", 32'(eUnaligned), 32'(expUna));
        checkVal("busy", 32'(busy), 32'(pend));
        if (expValid) begin
            checkVal("ePc", ePc, expPc);
            checkVal("eData", eData, expData);
            checkVal("eLoadKind", 32'(eLoadKind), 32'(expLoadKind));
            if (expRegWrite) checkVal("eRegId", 32'(eRegId), 32'(expRegId));
            if (expStore) checkVal("eWriteMemData", eWriteMemData, expWrData);
        end
    endtask

    task automatic driveNext();
        if (accepted || !inValid) begin // otherwise hold the instruction.
            if (issued < NumInstr && $urandom % 8 != 0) begin
                instr = genInstr();
                pc = $urandom & 32'hffff_fffc;
                rsData = randOperand();
                rtData = randOperand();
                inValid = 1'b1;
                issued++;
            end else begin
                inValid = 1'b0;
            end
        end
        mRegWrite = $urandom % 2 == 1;
        mRegId = pickReg();
        mData = randOperand();
        memStall = $urandom % 8 == 0;
        flush = $urandom % 40 == 0;
    endtask

    initial begin
        void'($urandom(32'h8e45));
        reset = 1'b1;
        inValid = 1'b0;
        instr = '0;
        pc = '0;
        rsData = '0;
        rtData = '0;
        mRegWrite = 1'b0;
        mRegId = '0;
        mData = '0;
        memStall = 1'b0;
        flush = 1'b0;
        loadBubble();
        expStore = 1'b0;
        pend = 1'b0;
        pendCnt = 0;
        accepted = 1'b0;
        repeat (10) @(posedge Clk);
        #5;
        reset = 1'b0;
        compareOutputs(); // control outputs low out of reset.
        driveNext();
        while (issued < NumInstr || inValid || pend) begin
            @(posedge Clk);
            clockModel();
            #1;
            compareOutputs();
            #4;
            driveNext();
        end
        $display("%0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
execPkg.sv
operandForward.sv
aluCore.sv
iterMultiplier.sv
memAccessDecode.sv
execControl.sv
execStage.sv
tbExecStage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbExecStage
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)
